//--- Makefile
# Verilator flow for the data-memory subsystem testbench

VERILATOR  ?= verilator
VFLAGS     ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
TOP        ?= tb_dmem_subsys
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/backing_mem.sv
`timescale 1ns/1ps
`default_nettype none

module backing_mem #(
  parameter int MEM_AW      = 8,
  // Read cycles counting the request cycle, at least 2
  parameter int MEM_LATENCY = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rd,
  input  logic [MEM_AW-1:0]           raddr,
  output logic [dmem_pkg::DATA_W-1:0] rdata,
  output logic                        rd_done,
  input  logic                        wr,
  input  logic [MEM_AW-1:0]           waddr,
  input  logic [dmem_pkg::DATA_W-1:0] wdata,
  input  logic [dmem_pkg::STRB_W-1:0] wstrb
);
  import dmem_pkg::*;

  localparam int CNT_W = $clog2(MEM_LATENCY);

  logic [DATA_W-1:0] mem [1 << MEM_AW];
  logic [MEM_AW-1:0] raddr_q;
  // Cycles left on the pending read, zero when idle
  logic [CNT_W-1:0]  cnt;

  initial begin
    for (int i = 0; i < (1 << MEM_AW); i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (rd) begin
      cnt <= CNT_W'(MEM_LATENCY - 1);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      raddr_q <= raddr;
    end
    // Byte lanes written at the edge
    if (wr) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb[b]) begin
          mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Last cycle of the countdown returns the word
  assign rd_done = (cnt == CNT_W'(1));
  assign rdata   = mem[raddr_q];

  // Only one read in flight from the cache
  a_no_overlap_rd: assert property (@(posedge clk) disable iff (!rst_n)
    rd |-> cnt == '0);

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache #(
  parameter int INDEX_W = 4,
  parameter int MEM_AW  = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // Read request from the bridge
  input  logic                        rd_valid,
  input  logic [dmem_pkg::ADDR_W-1:0] rd_addr,
  output logic [dmem_pkg::DATA_W-1:0] rd_data,
  output logic                        rd_data_valid,
  // Write request from the bridge
  input  logic                        wr_valid,
  input  logic [dmem_pkg::ADDR_W-1:0] wr_addr,
  input  logic [dmem_pkg::DATA_W-1:0] wr_data,
  input  logic [dmem_pkg::STRB_W-1:0] wr_strb,
  output logic                        wr_ready,
  // Backing memory
  output logic                        mem_rd,
  output logic [MEM_AW-1:0]           mem_raddr,
  input  logic [dmem_pkg::DATA_W-1:0] mem_rdata,
  input  logic                        mem_rd_done,
  output logic                        mem_wr,
  output logic [MEM_AW-1:0]           mem_waddr,
  output logic [dmem_pkg::DATA_W-1:0] mem_wdata,
  output logic [dmem_pkg::STRB_W-1:0] mem_wstrb
);
  import dmem_pkg::*;

  localparam int TAG_W = MEM_AW - INDEX_W;
  localparam int LINES = 1 << INDEX_W;

  cache_state_t       state;
  cache_state_t       state_next;

  // One word per line
  logic [DATA_W-1:0]  data_arr [LINES];
  logic [TAG_W-1:0]   tag_arr  [LINES];
  logic [LINES-1:0]   valid;

  // Word address split into index and tag
  logic [MEM_AW-1:0]  rd_word;
  logic [MEM_AW-1:0]  wr_word;
  logic [INDEX_W-1:0] rd_idx;
  logic [INDEX_W-1:0] wr_idx;
  logic [TAG_W-1:0]   rd_tag;
  logic [TAG_W-1:0]   wr_tag;
  logic               rd_hit;
  logic               wr_hit;

  // Set once mem_rd has gone out for the current fill
  logic               fill_issued;
  logic [DATA_W-1:0]  merged;

  assign rd_word = rd_addr[MEM_AW+1:2];
  assign wr_word = wr_addr[MEM_AW+1:2];
  assign rd_idx  = rd_word[INDEX_W-1:0];
  assign wr_idx  = wr_word[INDEX_W-1:0];
  assign rd_tag  = rd_word[MEM_AW-1:INDEX_W];
  assign wr_tag  = wr_word[MEM_AW-1:INDEX_W];
  assign rd_hit  = valid[rd_idx] && (tag_arr[rd_idx] == rd_tag);
  assign wr_hit  = valid[wr_idx] && (tag_arr[wr_idx] == wr_tag);

  // Store bytes laid over the cached word
  always_comb begin
    merged = data_arr[wr_idx];
    for (int b = 0; b < STRB_W; b++) begin
      if (wr_strb[b]) begin
        merged[8*b +: 8] = wr_data[8*b +: 8];
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      CACHE_IDLE: begin
        if (rd_valid) begin
          state_next = CACHE_LOOKUP;
        end else if (wr_valid) begin
          state_next = CACHE_WRITE;
        end
      end
      CACHE_LOOKUP: begin
        state_next = rd_hit ? CACHE_IDLE : CACHE_FILL;
      end
      CACHE_FILL: begin
        if (mem_rd_done) begin
          state_next = CACHE_IDLE;
        end
      end
      default: begin
        // Write-through finishes in one cycle
        state_next = CACHE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= CACHE_IDLE;
      fill_issued <= 1'b0;
      valid       <= '0;
    end else begin
      state       <= state_next;
      fill_issued <= (state == CACHE_FILL) && (state_next == CACHE_FILL);
      if (state == CACHE_FILL && mem_rd_done) begin
        valid[rd_idx] <= 1'b1;
      end
    end
  end

  // Line contents, refilled on a miss or merged on a write hit
  always_ff @(posedge clk) begin
    if (state == CACHE_FILL && mem_rd_done) begin
      data_arr[rd_idx] <= mem_rdata;
      tag_arr[rd_idx]  <= rd_tag;
    end else if (state == CACHE_WRITE && wr_hit) begin
      data_arr[wr_idx] <= merged;
    end
  end

  // Fill data goes straight through in the done cycle
  assign rd_data       = (state == CACHE_FILL) ? mem_rdata : data_arr[rd_idx];
  assign rd_data_valid = (state == CACHE_LOOKUP && rd_hit) ||
                         (state == CACHE_FILL && mem_rd_done);
  assign wr_ready      = (state == CACHE_WRITE);

  assign mem_rd    = (state == CACHE_FILL) && !fill_issued;
  assign mem_raddr = rd_word;

  // Every store goes to memory, hit or not
  assign mem_wr    = (state == CACHE_WRITE);
  assign mem_waddr = wr_word;
  assign mem_wdata = wr_data;
  assign mem_wstrb = wr_strb;

  // IDLE favours the load, so a store offered alongside it would be lost
  a_req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_valid && wr_valid));

  // A fetch only follows a lookup that missed
  a_mem_rd_after_miss: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rd |-> (state == CACHE_FILL) && ($past(state) == CACHE_LOOKUP));

endmodule

`default_nettype wire

//--- rtl/dmem_cache_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_cache_bridge (
  input  logic                        clk,
  input  logic                        rst_n,
  // CPU load port
  input  logic                        dmem_ren,
  input  logic [dmem_pkg::ADDR_W-1:0] dmem_raddr,
  output logic [dmem_pkg::DATA_W-1:0] dmem_rdata,
  // CPU store port
  input  logic                        dmem_we,
  input  logic [dmem_pkg::ADDR_W-1:0] dmem_waddr,
  input  logic [dmem_pkg::DATA_W-1:0] dmem_wdata,
  input  logic [dmem_pkg::STRB_W-1:0] dmem_wstrb,
  output logic                        dmem_stall,
  // Cache read side
  output logic                        cache_rd_valid,
  output logic [dmem_pkg::ADDR_W-1:0] cache_rd_addr,
  input  logic [dmem_pkg::DATA_W-1:0] cache_rd_data,
  input  logic                        cache_rd_data_valid,
  // Cache write side
  output logic                        cache_wr_valid,
  output logic [dmem_pkg::ADDR_W-1:0] cache_wr_addr,
  output logic [dmem_pkg::DATA_W-1:0] cache_wr_data,
  output logic [dmem_pkg::STRB_W-1:0] cache_wr_strb,
  input  logic                        cache_wr_ready,
  // I/O RAM
  output logic                        io_ren,
  output logic [dmem_pkg::ADDR_W-1:0] io_raddr,
  input  logic [dmem_pkg::DATA_W-1:0] io_rdata,
  output logic                        io_wen,
  output logic [dmem_pkg::ADDR_W-1:0] io_waddr,
  output logic [dmem_pkg::DATA_W-1:0] io_wdata,
  output logic [dmem_pkg::STRB_W-1:0] io_wstrb
);
  import dmem_pkg::*;

  bridge_state_t     state;
  bridge_state_t     state_next;

  // High bit of the address picks I/O over the cache
  logic              io_sel_rd;
  logic              io_sel_wr;

  // Cycle right after a cache completion, stall still high
  logic              cooldown;
  // Stall low, CPU consumes the result while its old request is still up
  logic              retire;
  logic              accept;

  // Which source the last accepted load came from
  logic              io_sel_rd_q;

  // Request payload held for the cache
  logic [ADDR_W-1:0] rd_addr_q;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [DATA_W-1:0] wr_data_q;
  logic [STRB_W-1:0] wr_strb_q;

  // Completed cache load, held for the CPU
  logic [DATA_W-1:0] rd_data_q;

  assign io_sel_rd = dmem_raddr[IO_SEL_BIT];
  assign io_sel_wr = dmem_waddr[IO_SEL_BIT];

  // New requests only in a quiet IDLE
  assign accept = (state == BRIDGE_IDLE) && !cooldown && !retire;

  always_comb begin
    state_next = state;
    case (state)
      BRIDGE_IDLE: begin
        if (accept && dmem_ren && !io_sel_rd) begin
          state_next = BRIDGE_READ;
        end else if (accept && dmem_we && !io_sel_wr) begin
          state_next = BRIDGE_WRITE;
        end
      end
      BRIDGE_READ: begin
        if (cache_rd_data_valid) begin
          state_next = BRIDGE_IDLE;
        end
      end
      BRIDGE_WRITE: begin
        if (cache_wr_ready) begin
          state_next = BRIDGE_IDLE;
        end
      end
      default: begin
        state_next = BRIDGE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= BRIDGE_IDLE;
      cooldown    <= 1'b0;
      retire      <= 1'b0;
      io_sel_rd_q <= 1'b0;
    end else begin
      state    <= state_next;
      cooldown <= (state == BRIDGE_READ && cache_rd_data_valid) ||
                  (state == BRIDGE_WRITE && cache_wr_ready);
      retire   <= cooldown;
      // Track the source of each accepted load for the data mux
      if (accept && dmem_ren) begin
        io_sel_rd_q <= io_sel_rd;
      end
    end
  end

  // Capture payload as the request leaves IDLE
  always_ff @(posedge clk) begin
    if (state == BRIDGE_IDLE && state_next == BRIDGE_READ) begin
      rd_addr_q <= dmem_raddr;
    end
    if (state == BRIDGE_IDLE && state_next == BRIDGE_WRITE) begin
      wr_addr_q <= dmem_waddr;
      wr_data_q <= dmem_wdata;
      wr_strb_q <= dmem_wstrb;
    end
    // Load result stays put until the next load completes
    if (state == BRIDGE_READ && cache_rd_data_valid) begin
      rd_data_q <= cache_rd_data;
    end
  end

  // Read valid falls in the data cycle so the cache sees one request
  assign cache_rd_valid = (state == BRIDGE_READ) && !cache_rd_data_valid;
  assign cache_rd_addr  = rd_addr_q;

  assign cache_wr_valid = (state == BRIDGE_WRITE);
  assign cache_wr_addr  = wr_addr_q;
  assign cache_wr_data  = wr_data_q;
  assign cache_wr_strb  = wr_strb_q;

  // I/O path is straight through, the BRAM answers next cycle
  assign io_ren   = dmem_ren && io_sel_rd;
  assign io_raddr = dmem_raddr;
  assign io_wen   = dmem_we && io_sel_wr;
  assign io_waddr = dmem_waddr;
  assign io_wdata = dmem_wdata;
  assign io_wstrb = dmem_wstrb;

  assign dmem_rdata = io_sel_rd_q ? io_rdata : rd_data_q;

  // High from the request cycle through cooldown
  assign dmem_stall = (state != BRIDGE_IDLE) || (state_next != BRIDGE_IDLE) || cooldown;

  // CPU keeps loads and stores in separate cycles
  a_no_rd_wr_together: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_ren && dmem_we));

  // Payload must not move under a held valid
  a_rd_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cache_rd_valid && $past(cache_rd_valid) |-> $stable(cache_rd_addr));

  a_wr_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cache_wr_valid && $past(cache_wr_valid) |->
      $stable(cache_wr_addr) && $stable(cache_wr_data) && $stable(cache_wr_strb));

endmodule

`default_nettype wire

//--- rtl/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

  // Byte address width, one full word
  localparam int ADDR_W = 32;

  // Data word width
  localparam int DATA_W = 32;

  // One strobe bit per byte lane
  localparam int STRB_W = DATA_W / 8;

  // Address bit that routes an access to the I/O RAM
  localparam int IO_SEL_BIT = 31;

  // CPU-side bridge FSM
  typedef enum logic [1:0] {
    BRIDGE_IDLE,
    BRIDGE_READ,
    BRIDGE_WRITE
  } bridge_state_t;

  // Data cache FSM
  typedef enum logic [1:0] {
    CACHE_IDLE,
    CACHE_LOOKUP,
    CACHE_FILL,
    CACHE_WRITE
  } cache_state_t;

endpackage

`default_nettype wire

//--- rtl/dmem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys #(
  parameter int INDEX_W     = 4,
  parameter int MEM_LATENCY = 4,
  parameter int MEM_AW      = 8,
  parameter int IO_AW       = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        dmem_ren,
  input  logic [dmem_pkg::ADDR_W-1:0] dmem_raddr,
  output logic [dmem_pkg::DATA_W-1:0] dmem_rdata,
  input  logic                        dmem_we,
  input  logic [dmem_pkg::ADDR_W-1:0] dmem_waddr,
  input  logic [dmem_pkg::DATA_W-1:0] dmem_wdata,
  input  logic [dmem_pkg::STRB_W-1:0] dmem_wstrb,
  output logic                        dmem_stall
);
  import dmem_pkg::*;

  // Bridge to cache
  logic              cache_rd_valid;
  logic [ADDR_W-1:0] cache_rd_addr;
  logic [DATA_W-1:0] cache_rd_data;
  logic              cache_rd_data_valid;
  logic              cache_wr_valid;
  logic [ADDR_W-1:0] cache_wr_addr;
  logic [DATA_W-1:0] cache_wr_data;
  logic [STRB_W-1:0] cache_wr_strb;
  logic              cache_wr_ready;

  // Cache to backing memory
  logic              mem_rd;
  logic [MEM_AW-1:0] mem_raddr;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_rd_done;
  logic              mem_wr;
  logic [MEM_AW-1:0] mem_waddr;
  logic [DATA_W-1:0] mem_wdata;
  logic [STRB_W-1:0] mem_wstrb;

  // Bridge to I/O RAM
  logic              io_ren;
  logic [ADDR_W-1:0] io_raddr;
  logic [DATA_W-1:0] io_rdata;
  logic              io_wen;
  logic [ADDR_W-1:0] io_waddr;
  logic [DATA_W-1:0] io_wdata;
  logic [STRB_W-1:0] io_wstrb;

  dmem_cache_bridge u_bridge (
    .clk, .rst_n,
    .dmem_ren, .dmem_raddr, .dmem_rdata,
    .dmem_we, .dmem_waddr, .dmem_wdata, .dmem_wstrb, .dmem_stall,
    .cache_rd_valid, .cache_rd_addr, .cache_rd_data, .cache_rd_data_valid,
    .cache_wr_valid, .cache_wr_addr, .cache_wr_data, .cache_wr_strb, .cache_wr_ready,
    .io_ren, .io_raddr, .io_rdata, .io_wen, .io_waddr, .io_wdata, .io_wstrb
  );

  dcache #(.INDEX_W(INDEX_W), .MEM_AW(MEM_AW)) u_dcache (
    .clk, .rst_n,
    .rd_valid(cache_rd_valid), .rd_addr(cache_rd_addr),
    .rd_data(cache_rd_data), .rd_data_valid(cache_rd_data_valid),
    .wr_valid(cache_wr_valid), .wr_addr(cache_wr_addr),
    .wr_data(cache_wr_data), .wr_strb(cache_wr_strb), .wr_ready(cache_wr_ready),
    .mem_rd, .mem_raddr, .mem_rdata, .mem_rd_done,
    .mem_wr, .mem_waddr, .mem_wdata, .mem_wstrb
  );

  backing_mem #(.MEM_AW(MEM_AW), .MEM_LATENCY(MEM_LATENCY)) u_backing_mem (
    .clk, .rst_n,
    .rd(mem_rd), .raddr(mem_raddr), .rdata(mem_rdata), .rd_done(mem_rd_done),
    .wr(mem_wr), .waddr(mem_waddr), .wdata(mem_wdata), .wstrb(mem_wstrb)
  );

  io_bram #(.IO_AW(IO_AW)) u_io_bram (
    .clk,
    .ren(io_ren), .raddr(io_raddr), .rdata(io_rdata),
    .wen(io_wen), .waddr(io_waddr), .wdata(io_wdata), .wstrb(io_wstrb)
  );

endmodule

`default_nettype wire

//--- rtl/io_bram.sv
`timescale 1ns/1ps
`default_nettype none

module io_bram #(
  parameter int IO_AW = 4
) (
  input  logic                        clk,
  input  logic                        ren,
  input  logic [dmem_pkg::ADDR_W-1:0] raddr,
  output logic [dmem_pkg::DATA_W-1:0] rdata,
  input  logic                        wen,
  input  logic [dmem_pkg::ADDR_W-1:0] waddr,
  input  logic [dmem_pkg::DATA_W-1:0] wdata,
  input  logic [dmem_pkg::STRB_W-1:0] wstrb
);
  import dmem_pkg::*;

  logic [DATA_W-1:0] mem [1 << IO_AW];

  // Word index from the low address bits
  logic [IO_AW-1:0]  ridx;
  logic [IO_AW-1:0]  widx;

  assign ridx = raddr[IO_AW+1:2];
  assign widx = waddr[IO_AW+1:2];

  initial begin
    for (int i = 0; i < (1 << IO_AW); i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    // Registered read, data next cycle
    if (ren) begin
      rdata <= mem[ridx];
    end
    if (wen) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb[b]) begin
          mem[widx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/dmem_pkg.sv
rtl/io_bram.sv
rtl/backing_mem.sv
rtl/dcache.sv
rtl/dmem_cache_bridge.sv
rtl/dmem_subsys.sv
tb/tb_dmem_subsys.sv

//--- tb/tb_dmem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_subsys;
  import dmem_pkg::*;

  localparam int INDEX_W     = 4;
  localparam int MEM_LATENCY = 4;
  localparam int MEM_AW      = 8;
  localparam int IO_AW       = 4;
  localparam int TAG_W       = MEM_AW - INDEX_W;
  localparam int NUM_OPS     = 400;
  // A miss plus one idle cycle is the longest operation
  localparam int TIMEOUT     = NUM_OPS * (MEM_LATENCY + 8) + 100;

  typedef enum logic [2:0] {OP_NONE, OP_IRD, OP_IWR, OP_CRD, OP_CWR} op_t;

  logic              clk;
  logic              rst_n;
  logic              dmem_ren;
  logic [ADDR_W-1:0] dmem_raddr;
  logic [DATA_W-1:0] dmem_rdata;
  logic              dmem_we;
  logic [ADDR_W-1:0] dmem_waddr;
  logic [DATA_W-1:0] dmem_wdata;
  logic [STRB_W-1:0] dmem_wstrb;
  logic              dmem_stall;

  // Operation in flight, changed only on the falling edge
  op_t               op_kind;
  logic              fresh;
  int                exp_len;
  logic [DATA_W-1:0] exp_data;

  // Registered observations for the checks
  logic              stall_q;
  int                stall_cnt;
  logic              io_chk_q;
  logic [DATA_W-1:0] io_exp_q;
  int                cycles;

  // Reference memories and a shadow of the cache tags
  logic [DATA_W-1:0] mem_model  [1 << MEM_AW];
  logic [DATA_W-1:0] io_model   [1 << IO_AW];
  logic              line_valid [1 << INDEX_W];
  logic [TAG_W-1:0]  line_tag   [1 << INDEX_W];

  integer            seed;

  dmem_subsys #(
    .INDEX_W(INDEX_W), .MEM_LATENCY(MEM_LATENCY), .MEM_AW(MEM_AW), .IO_AW(IO_AW)
  ) DUT (
    .clk, .rst_n,
    .dmem_ren, .dmem_raddr, .dmem_rdata,
    .dmem_we, .dmem_waddr, .dmem_wdata, .dmem_wstrb,
    .dmem_stall
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  endtask

  task automatic report_error(input string text);
    $display("ERROR at %0t: %s", $time, text);
    abort_run();
  endtask

  // Byte lanes with their strobe set replace the old word
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Stall history and the one-cycle-late I/O read check
  always @(posedge clk) begin
    if (!rst_n) begin
      stall_q   <= 1'b0;
      stall_cnt <= 0;
      io_chk_q  <= 1'b0;
    end else begin
      stall_q   <= dmem_stall;
      stall_cnt <= dmem_stall ? stall_cnt + 1 : 0;
      io_chk_q  <= (op_kind == OP_IRD) && !dmem_stall;
    end
    io_exp_q <= exp_data;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      report_error("run timed out before all operations finished");
    end
  end

  // Stall only while a cached request is held
  a_stall_only_cached: assert property (@(posedge clk) disable iff (!rst_n)
    !(op_kind == OP_CRD || op_kind == OP_CWR) |-> !dmem_stall)
    else report_mismatch("dmem_stall", 32'd0, 32'($sampled(dmem_stall)));

  // Hit, miss and write each have a fixed stall length
  a_stall_length: assert property (@(posedge clk) disable iff (!rst_n)
    stall_q && !dmem_stall |-> stall_cnt == exp_len)
    else report_mismatch("dmem_stall cycles", $sampled(exp_len), $sampled(stall_cnt));

  // The held old request must not raise stall again
  a_rise_on_new_req: assert property (@(posedge clk) disable iff (!rst_n)
    !stall_q && dmem_stall |-> fresh)
    else report_error("stall rose without a new cached request");

  a_cached_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    op_kind == OP_CRD && !dmem_stall |-> dmem_rdata == exp_data)
    else report_mismatch("dmem_rdata", $sampled(exp_data), $sampled(dmem_rdata));

  a_io_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    io_chk_q |-> dmem_rdata == io_exp_q)
    else report_mismatch("dmem_rdata (I/O)", $sampled(io_exp_q), $sampled(dmem_rdata));

  // Drive one request on the falling edge and hold it until accepted
  task automatic run_op(input op_t kind, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    logic [MEM_AW-1:0]  word;
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic [IO_AW-1:0]   io_idx;
    word    = addr[MEM_AW+1:2];
    idx     = word[INDEX_W-1:0];
    tag     = word[MEM_AW-1:INDEX_W];
    io_idx  = addr[IO_AW+1:2];
    exp_len = 4;
    if (kind == OP_IRD) begin
      exp_data = io_model[io_idx];
    end else if (kind == OP_CRD) begin
      exp_data = mem_model[word];
      // No write-allocate, so only fills make a line valid
      if (!(line_valid[idx] && line_tag[idx] == tag)) begin
        exp_len = 4 + MEM_LATENCY;
      end
    end
    op_kind    = kind;
    fresh      = (kind == OP_CRD) || (kind == OP_CWR);
    dmem_ren   = (kind == OP_IRD) || (kind == OP_CRD);
    dmem_raddr = addr;
    dmem_we    = (kind == OP_IWR) || (kind == OP_CWR);
    dmem_waddr = addr;
    dmem_wdata = data;
    dmem_wstrb = strb;
    @(negedge clk);
    fresh = 1'b0;
    while (stall_q) begin
      @(negedge clk);
    end
    if (kind == OP_IWR) begin
      io_model[io_idx] = merge_bytes(io_model[io_idx], data, strb);
    end else if (kind == OP_CWR) begin
      mem_model[word] = merge_bytes(mem_model[word], data, strb);
    end else if (kind == OP_CRD) begin
      line_valid[idx] = 1'b1;
      line_tag[idx]   = tag;
    end
    op_kind  = OP_NONE;
    dmem_ren = 1'b0;
    dmem_we  = 1'b0;
  endtask

  initial begin
    logic [31:0]       r;
    logic [DATA_W-1:0] data;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] last_caddr;
    op_t               kind;
    seed       = 32'hcbc7;
    cycles     = 0;
    rst_n      = 1'b0;
    dmem_ren   = 1'b0;
    dmem_raddr = '0;
    dmem_we    = 1'b0;
    dmem_waddr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    op_kind    = OP_NONE;
    fresh      = 1'b0;
    exp_len    = 0;
    exp_data   = '0;
    last_caddr = '0;
    for (int i = 0; i < (1 << MEM_AW); i++) begin
      mem_model[i] = '0;
    end
    for (int i = 0; i < (1 << IO_AW); i++) begin
      io_model[i] = '0;
    end
    for (int i = 0; i < (1 << INDEX_W); i++) begin
      line_valid[i] = 1'b0;
      line_tag[i]   = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_OPS; i++) begin
      r    = $random(seed);
      data = $random(seed);
      case (r[4:2])
        3'd0, 3'd1: kind = OP_CRD;
        3'd2, 3'd3: kind = OP_CWR;
        3'd4, 3'd5: kind = OP_IRD;
        default:    kind = OP_IWR;
      endcase
      if (kind == OP_CRD || kind == OP_CWR) begin
        // Four tags over four lines, often the same address again
        if (r[11:10] == 2'b00) begin
          addr = last_caddr;
        end else begin
          addr = {22'd0, 2'b00, r[9:8], 2'b00, r[1:0], 2'b00};
        end
        last_caddr = addr;
      end else begin
        addr = {1'b1, 27'd0, r[13:12], 2'b00};
      end
      run_op(kind, addr, data, r[18] ? 4'hf : r[17:14]);
      if (r[20]) begin
        @(negedge clk);
      end
    end
    // Room for the last I/O read check
    repeat (2) @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
